//--- flist.f
busTypesPkg.sv
ramTypesPkg.sv
busArbiter.sv
snoopUnit.sv
coherenceFsm.sv
busCtrl.sv
tbClockGen.sv
busCtrlTb.sv

//--- Bender.yml
package:
  name: busctrl

sources:
  - busTypesPkg.sv
  - ramTypesPkg.sv
  - busArbiter.sv
  - snoopUnit.sv
  - coherenceFsm.sv
  - busCtrl.sv
  - target: test
    files:
      - tbClockGen.sv
      - busCtrlTb.sv

//--- busCtrlTb.sv
`timescale 1ns/100ps
`default_nettype none

module busCtrlTb;
    import busTypesPkg::*;
    import ramTypesPkg::*;

    localparam int RandomTx = 40;
    localparam int NumTx = 12 + RandomTx;
    // accept, snoop round trip with cache delay, two RAM beats, respond
    localparam int WorstSeqLen = 12;
    localparam int CycleLimit = 20 * NumTx * WorstSeqLen;

    logic CLK;
    logic nRST;
    dataReqT [NumCores-1:0] dataReq;
    logic [NumCores-1:0] dataReqValid;
    logic [NumCores-1:0] dataReqReady;
    dataRespT [NumCores-1:0] dataResp;
    logic [NumCores-1:0] dataRespValid;
    logic [NumCores-1:0] dataRespReady;
    instReqT [NumCores-1:0] instReq;
    logic [NumCores-1:0] instReqValid;
    logic [NumCores-1:0] instReqReady;
    instRespT [NumCores-1:0] instResp;
    logic [NumCores-1:0] instRespValid;
    logic [NumCores-1:0] instRespReady;
    snoopReqT [NumCores-1:0] snoopReq;
    logic [NumCores-1:0] snoopReqValid;
    logic [NumCores-1:0] snoopReqReady;
    snoopRespT [NumCores-1:0] snoopResp;
    logic [NumCores-1:0] snoopRespValid;
    logic [NumCores-1:0] snoopRespReady;
    ramReqT ramReq;
    logic ramReqValid;
    logic ramReady;
    wordT ramLoad;

    // RAM model, reference image and per-core cache models
    wordT ram [256];
    wordT refRam [256];
    logic cacheValid [NumCores][128];
    logic cacheMod [NumCores][128];
    blockT cacheData [NumCores][128];
    snoopReqT snoopHeld [NumCores];
    logic snoopBusy [NumCores];
    logic [1:0] snoopDelay [NumCores];
    logic [NumCores-1:0] dataWaiting;
    logic [NumCores-1:0] instWaiting;
    dataRespT dataExp [NumCores][$];
    instRespT instExp [NumCores][$];
    snoopReqT snoopExp [NumCores][$];
    ramReqT ramExp [$];
    int acceptLog [$];
    int outstanding = 0;
    int errorCount = 0;
    int cycles = 0;
    logic [31:0] lfsrState = 32'h3d2904d8;

    tbClockGen clkGen (.CLK(CLK), .nRST(nRST));

    busCtrl dut (.*);

    function automatic logic randBit();
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        return lfsrState[0];
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
            bits = {bits[30:0], randBit()};
        return bits;
    endfunction

    // initial RAM contents mixed from the full byte address
    function automatic wordT fillWord(input int idx);
        logic [31:0] addr;
        addr = idx << 2;
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    // byte address of word w in block b
    function automatic ramAddrT wordAddr(input blockAddrT b, input int w);
        return ramAddrT'((int'(b) * WordsPerBlock + w) * 4);
    endfunction

    function automatic dataReqT makeReq(input reqKindT kind, input int blk, input blockT b);
        dataReqT r;
        r.kind = kind;
        r.blockAddr = blockAddrT'(blk);
        r.block = b;
        return r;
    endfunction

    // expected data block is zero for writeBack and a dirty partner wins over RAM
    function automatic blockT refBlock(input coreIdT core, input dataReqT req);
        coreIdT partner;
        int blk;
        partner = ~core;
        blk = int'(req.blockAddr[6:0]);
        if (req.kind == writeBack)
            return '0;
        if (cacheMod[partner][blk])
            return cacheData[partner][blk];
        return {refRam[2 * blk + 1], refRam[2 * blk]};
    endfunction

    function automatic wordT refInstr(input wordT addr);
        return refRam[addr[9:2]];
    endfunction

    task automatic reportError(input string msg);
        errorCount++;
        $display("** Error at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkData(input dataRespT got, input dataRespT exp, input int core);
        if (got !== exp)
            reportError($sformatf("core %0d data block %h, expected %h",
                core, got.block, exp.block));
    endtask

    task automatic checkInst(input instRespT got, input instRespT exp, input int core);
        if (got !== exp)
            reportError($sformatf("core %0d instruction %h, expected %h",
                core, got.instr, exp.instr));
    endtask

    task automatic checkSnoop(input snoopReqT got, input snoopReqT exp, input int core);
        if (got !== exp)
            reportError($sformatf("core %0d snoop block %h invalidate %b, expected %h %b",
                core, got.blockAddr, got.invalidate, exp.blockAddr, exp.invalidate));
    endtask

    task automatic checkRam(input ramReqT got, input ramReqT exp);
        if (got.addr !== exp.addr || got.write !== exp.write
                || (exp.write && got.store !== exp.store))
            reportError($sformatf("RAM request addr %h write %b store %h, expected %h %b %h",
                got.addr, got.write, got.store, exp.addr, exp.write, exp.store));
    endtask

    // queue the expected response and RAM traffic, then update the requester's copy
    task automatic predictData(input coreIdT core, input dataReqT req);
        dataRespT exp;
        ramReqT r;
        blockT wr;
        int blk;
        logic writes;
        snoopReqT s;
        blk = int'(req.blockAddr[6:0]);
        exp.block = refBlock(core, req);
        writes = (req.kind == writeBack) || cacheMod[~core][blk];
        wr = (req.kind == writeBack) ? req.block : exp.block;
        if (req.kind != writeBack) begin
            s.blockAddr = req.blockAddr;
            s.invalidate = (req.kind == busReadX);
            snoopExp[~core].push_back(s);
        end
        for (int w = 0; w < WordsPerBlock; w++) begin
            r.addr = wordAddr(req.blockAddr, w);
            r.write = writes;
            r.store = wr[w];
            ramExp.push_back(r);
            if (writes)
                refRam[2 * blk + w] = wr[w];
        end
        dataExp[core].push_back(exp);
        outstanding++;
        if (req.kind == writeBack) begin
            cacheValid[core][blk] = 1'b0;
            cacheMod[core][blk] = 1'b0;
        end else begin
            // an owned block gets dirtied by a store right away
            cacheValid[core][blk] = 1'b1;
            cacheMod[core][blk] = (req.kind == busReadX);
            cacheData[core][blk] = (req.kind == busReadX)
                ? {randBits(32), randBits(32)} : exp.block;
        end
    endtask

    task automatic predictInst(input coreIdT core, input wordT addr);
        instRespT exp;
        ramReqT r;
        exp.instr = refInstr(addr);
        r.addr = addr;
        r.write = 1'b0;
        r.store = '0;
        ramExp.push_back(r);
        instExp[core].push_back(exp);
        outstanding++;
    endtask

    task automatic sendData(input coreIdT core, input dataReqT req);
        @(negedge CLK);
        dataReq[core] = req;
        dataReqValid[core] = 1'b1;
        do
            @(posedge CLK);
        while (!dataReqReady[core]);
        @(negedge CLK);
        dataReqValid[core] = 1'b0;
        dataReq[core] = '0;
    endtask

    task automatic sendInst(input coreIdT core, input wordT addr);
        @(negedge CLK);
        instReq[core].addr = addr;
        instReqValid[core] = 1'b1;
        do
            @(posedge CLK);
        while (!instReqReady[core]);
        @(negedge CLK);
        instReqValid[core] = 1'b0;
        instReq[core] = '0;
    endtask

    task automatic drain();
        wait (outstanding == 0);
        @(negedge CLK);
    endtask

    task automatic runData(input coreIdT core, input dataReqT req);
        predictData(core, req);
        sendData(core, req);
        drain();
    endtask

    task automatic runInst(input coreIdT core, input wordT addr);
        predictInst(core, addr);
        sendInst(core, addr);
        drain();
    endtask

    // RAM answers in the same cycle and caches answer snoops after a random delay
    always @(negedge CLK) begin
        ramReady = randBit();
        ramLoad = ram[ramReq.addr[9:2]];
        for (int c = 0; c < NumCores; c++) begin
            snoopReqReady[c] = randBit();
            dataRespReady[c] = randBit();
            instRespReady[c] = randBit();
            snoopRespValid[c] = snoopBusy[c] && (snoopDelay[c] == 2'd0);
            if (snoopBusy[c] && snoopDelay[c] != 2'd0)
                snoopDelay[c] = snoopDelay[c] - 2'd1;
            snoopResp[c].dirty = cacheMod[c][snoopHeld[c].blockAddr[6:0]];
            snoopResp[c].block = cacheData[c][snoopHeld[c].blockAddr[6:0]];
        end
    end

    always @(posedge CLK) begin : monitor
        int blk;
        if (nRST) begin
            if (ramReqValid && ramReady) begin
                if (ramExp.size() == 0)
                    reportError("RAM request issued with none expected");
                checkRam(ramReq, ramExp.pop_front());
                if (ramReq.write)
                    ram[ramReq.addr[9:2]] = ramReq.store;
            end
            for (int c = 0; c < NumCores; c++) begin
                if (dataWaiting[c] && !dataRespValid[c])
                    reportError($sformatf("core %0d data response dropped unaccepted", c));
                if (instWaiting[c] && !instRespValid[c])
                    reportError($sformatf("core %0d instruction response dropped unaccepted", c));
                dataWaiting[c] = dataRespValid[c] && !dataRespReady[c];
                instWaiting[c] = instRespValid[c] && !instRespReady[c];
                if (dataRespValid[c] && dataRespReady[c]) begin
                    if (dataExp[c].size() == 0)
                        reportError($sformatf("core %0d got an unexpected data response", c));
                    checkData(dataResp[c], dataExp[c].pop_front(), c);
                    outstanding--;
                end
                if (instRespValid[c] && instRespReady[c]) begin
                    if (instExp[c].size() == 0)
                        reportError($sformatf("core %0d got an unexpected instruction", c));
                    checkInst(instResp[c], instExp[c].pop_front(), c);
                    outstanding--;
                end
                if (dataReqValid[c] && dataReqReady[c])
                    acceptLog.push_back(c);
                if (instReqValid[c] && instReqReady[c])
                    acceptLog.push_back(2 + c);
                // snooped copy goes shared, or invalid on busReadX
                if (snoopRespValid[c] && snoopRespReady[c]) begin
                    blk = int'(snoopHeld[c].blockAddr[6:0]);
                    snoopBusy[c] = 1'b0;
                    cacheMod[c][blk] = 1'b0;
                    if (snoopHeld[c].invalidate)
                        cacheValid[c][blk] = 1'b0;
                end
                if (snoopReqValid[c] && snoopReqReady[c]) begin
                    if (snoopExp[c].size() == 0)
                        reportError($sformatf("core %0d snooped with none expected", c));
                    checkSnoop(snoopReq[c], snoopExp[c].pop_front(), c);
                    snoopHeld[c] = snoopReq[c];
                    snoopBusy[c] = 1'b1;
                    snoopDelay[c] = 2'(randBits(2));
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("timeout after %0d cycles, %0d responses outstanding", cycles, outstanding);
            $display("SOME TESTS FAILED");
            $fatal(1, "run did not finish");
        end
    end

    initial begin : stimulus
        blockT d;
        coreIdT core;
        logic [1:0] pick;
        dataReqT req;
        dataReq = '0;
        dataReqValid = '0;
        dataRespReady = '0;
        instReq = '0;
        instReqValid = '0;
        instRespReady = '0;
        snoopReqReady = '0;
        snoopResp = '0;
        snoopRespValid = '0;
        ramReady = 1'b0;
        ramLoad = '0;
        dataWaiting = '0;
        instWaiting = '0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = fillWord(i);
            refRam[i] = ram[i];
        end
        for (int c = 0; c < NumCores; c++) begin
            snoopHeld[c] = '0;
            snoopBusy[c] = 1'b0;
            snoopDelay[c] = 2'd0;
            for (int b = 0; b < 128; b++) begin
                cacheValid[c][b] = 1'b0;
                cacheMod[c][b] = 1'b0;
                cacheData[c][b] = '0;
            end
        end
        wait (nRST);
        @(negedge CLK);

        runInst(0, 32'h40);
        runInst(1, 32'h1fc);
        runData(0, makeReq(busRead, 3, '0));
        runData(1, makeReq(busRead, 5, '0));

        // dirty partner forwards its block and flushes it to RAM
        d = {randBits(32), randBits(32)};
        cacheValid[1][10] = 1'b1;
        cacheMod[1][10] = 1'b1;
        cacheData[1][10] = d;
        runData(0, makeReq(busRead, 10, '0));
        if (ram[20] !== d[0] || ram[21] !== d[1])
            reportError("block 10 was not written back to RAM");
        if (!cacheValid[1][10] || cacheMod[1][10])
            reportError("core 1 copy of block 10 is not shared after busRead");
        d = {randBits(32), randBits(32)};
        cacheValid[0][12] = 1'b1;
        cacheMod[0][12] = 1'b1;
        cacheData[0][12] = d;
        runData(1, makeReq(busReadX, 12, '0));
        if (ram[24] !== d[0] || ram[25] !== d[1])
            reportError("block 12 was not written back to RAM");
        if (cacheValid[0][12])
            reportError("core 0 copy of block 12 is still valid after busReadX");

        d = {randBits(32), randBits(32)};
        runData(0, makeReq(writeBack, 7, d));
        runData(1, makeReq(busRead, 7, '0));

        // all four ports at once with data first and core 0 first
        acceptLog.delete();
        predictData(0, makeReq(busRead, 20, '0));
        predictData(1, makeReq(busRead, 21, '0));
        predictInst(0, 32'h100);
        predictInst(1, 32'h104);
        fork
            sendData(0, makeReq(busRead, 20, '0));
            sendData(1, makeReq(busRead, 21, '0));
            sendInst(0, 32'h100);
            sendInst(1, 32'h104);
        join
        drain();
        if (acceptLog.size() != 4)
            reportError($sformatf("%0d requests accepted instead of 4", acceptLog.size()));
        for (int i = 0; i < 4; i++)
            if (acceptLog[i] != i)
                reportError($sformatf("acceptance %0d went to port %0d", i, acceptLog[i]));

        // random mix over a small set of blocks with some dirty on either side
        for (int b = 64; b < 80; b++) begin
            cacheValid[b % 2][b] = 1'b1;
            cacheMod[b % 2][b] = 1'b1;
            cacheData[b % 2][b] = {randBits(32), randBits(32)};
        end
        for (int n = 0; n < RandomTx; n++) begin
            core = coreIdT'(randBit());
            pick = 2'(randBits(2));
            if (pick == 2'd3) begin
                runInst(core, wordT'(randBits(8) << 2));
            end else begin
                req = makeReq(reqKindT'(pick), 64 + int'(randBits(4)),
                    {randBits(32), randBits(32)});
                runData(core, req);
            end
        end

        if (ramExp.size() != 0)
            reportError("expected RAM requests were never issued");
        if (snoopExp[0].size() != 0 || snoopExp[1].size() != 0)
            reportError("expected snoops were never issued");
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/100ps
`default_nettype none

module tbClockGen (
    output logic CLK,
    output logic nRST
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // eight cycles of reset, released on a falling edge
    initial begin
        nRST = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

//--- busCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module busCtrl (
    input  logic CLK,
    input  logic nRST,
    input  busTypesPkg::dataReqT [busTypesPkg::NumCores-1:0] dataReq,
    input  logic [busTypesPkg::NumCores-1:0] dataReqValid,
    output logic [busTypesPkg::NumCores-1:0] dataReqReady,
    output busTypesPkg::dataRespT [busTypesPkg::NumCores-1:0] dataResp,
    output logic [busTypesPkg::NumCores-1:0] dataRespValid,
    input  logic [busTypesPkg::NumCores-1:0] dataRespReady,
    input  busTypesPkg::instReqT [busTypesPkg::NumCores-1:0] instReq,
    input  logic [busTypesPkg::NumCores-1:0] instReqValid,
    output logic [busTypesPkg::NumCores-1:0] instReqReady,
    output busTypesPkg::instRespT [busTypesPkg::NumCores-1:0] instResp,
    output logic [busTypesPkg::NumCores-1:0] instRespValid,
    input  logic [busTypesPkg::NumCores-1:0] instRespReady,
    output busTypesPkg::snoopReqT [busTypesPkg::NumCores-1:0] snoopReq,
    output logic [busTypesPkg::NumCores-1:0] snoopReqValid,
    input  logic [busTypesPkg::NumCores-1:0] snoopReqReady,
    input  busTypesPkg::snoopRespT [busTypesPkg::NumCores-1:0] snoopResp,
    input  logic [busTypesPkg::NumCores-1:0] snoopRespValid,
    output logic [busTypesPkg::NumCores-1:0] snoopRespReady,
    output ramTypesPkg::ramReqT ramReq,
    output logic ramReqValid,
    input  logic ramReady,
    input  busTypesPkg::wordT ramLoad
);
    import busTypesPkg::*;

    grantT grant;
    logic idle;
    logic snoopStart;
    coreIdT snoopTarget;
    snoopReqT snoop;
    logic snoopDone;
    snoopRespT snoopResult;

    busArbiter arbiter (
        .CLK(CLK),
        .nRST(nRST),
        .dataReqValid(dataReqValid),
        .instReqValid(instReqValid),
        .idle(idle),
        .grant(grant)
    );

    // snoop channel to whichever core did not win
    snoopUnit snooper (
        .CLK(CLK),
        .nRST(nRST),
        .start(snoopStart),
        .target(snoopTarget),
        .snoop(snoop),
        .snoopReq(snoopReq),
        .snoopReqValid(snoopReqValid),
        .snoopReqReady(snoopReqReady),
        .snoopResp(snoopResp),
        .snoopRespValid(snoopRespValid),
        .snoopRespReady(snoopRespReady),
        .done(snoopDone),
        .result(snoopResult)
    );

    coherenceFsm sequencer (
        .CLK(CLK),
        .nRST(nRST),
        .grant(grant),
        .dataReq(dataReq),
        .dataReqReady(dataReqReady),
        .instReq(instReq),
        .instReqReady(instReqReady),
        .dataResp(dataResp),
        .dataRespValid(dataRespValid),
        .dataRespReady(dataRespReady),
        .instResp(instResp),
        .instRespValid(instRespValid),
        .instRespReady(instRespReady),
        .ramReq(ramReq),
        .ramReqValid(ramReqValid),
        .ramReady(ramReady),
        .ramLoad(ramLoad),
        .idle(idle),
        .snoopStart(snoopStart),
        .snoopTarget(snoopTarget),
        .snoop(snoop),
        .snoopDone(snoopDone),
        .snoopResult(snoopResult)
    );

endmodule

`default_nettype wire

//--- coherenceFsm.sv
`timescale 1ns/100ps
`default_nettype none

module coherenceFsm (
    input  logic CLK,
    input  logic nRST,
    input  busTypesPkg::grantT grant,
    input  busTypesPkg::dataReqT [busTypesPkg::NumCores-1:0] dataReq,
    output logic [busTypesPkg::NumCores-1:0] dataReqReady,
    input  busTypesPkg::instReqT [busTypesPkg::NumCores-1:0] instReq,
    output logic [busTypesPkg::NumCores-1:0] instReqReady,
    output busTypesPkg::dataRespT [busTypesPkg::NumCores-1:0] dataResp,
    output logic [busTypesPkg::NumCores-1:0] dataRespValid,
    input  logic [busTypesPkg::NumCores-1:0] dataRespReady,
    output busTypesPkg::instRespT [busTypesPkg::NumCores-1:0] instResp,
    output logic [busTypesPkg::NumCores-1:0] instRespValid,
    input  logic [busTypesPkg::NumCores-1:0] instRespReady,
    output ramTypesPkg::ramReqT ramReq,
    output logic ramReqValid,
    input  logic ramReady,
    input  busTypesPkg::wordT ramLoad,
    output logic idle,
    output logic snoopStart,
    output busTypesPkg::coreIdT snoopTarget,
    output busTypesPkg::snoopReqT snoop,
    input  logic snoopDone,
    input  busTypesPkg::snoopRespT snoopResult
);
    import busTypesPkg::*;
    import ramTypesPkg::*;

    typedef enum logic [3:0] {
        sIdle,
        sIFetch,
        sSnoop,
        sFlush0,
        sFlush1,
        sFill0,
        sFill1,
        sWrite0,
        sWrite1,
        sRespond
    } fsmStateT;

    fsmStateT state;
    logic isDataQ;
    coreIdT coreQ;
    reqKindT kindQ;
    blockAddrT blockAddrQ;
    blockT blockQ;
    wordT instAddrQ;

    dataReqT granted;
    logic acceptData;
    logic acceptInst;
    logic respReady;
    logic [WordIdxBits-1:0] wordIdx;

    assign idle = (state == sIdle);
    assign granted = dataReq[grant.core];
    assign acceptData = idle && grant.valid && grant.isData;
    assign acceptInst = idle && grant.valid && !grant.isData;

    // second word of the block in the *1 states
    assign wordIdx = (state == sFlush1 || state == sFill1 || state == sWrite1)
        ? WordIdxBits'(1) : WordIdxBits'(0);

    assign respReady = isDataQ ? dataRespReady[coreQ] : instRespReady[coreQ];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= sIdle;
            isDataQ <= 1'b0;
            coreQ <= '0;
            kindQ <= busRead;
        end else begin
            unique case (state)
                sIdle:
                    if (grant.valid) begin
                        isDataQ <= grant.isData;
                        coreQ <= grant.core;
                        kindQ <= granted.kind;
                        if (!grant.isData)
                            state <= sIFetch;
                        else if (granted.kind == writeBack)
                            state <= sWrite0;
                        else
                            state <= sSnoop;
                    end
                sIFetch:
                    if (ramReady)
                        state <= sRespond;
                // dirty partner means its block goes to RAM first
                sSnoop:
                    if (snoopDone)
                        state <= snoopResult.dirty ? sFlush0 : sFill0;
                sFlush0:
                    if (ramReady)
                        state <= sFlush1;
                sFill0:
                    if (ramReady)
                        state <= sFill1;
                sWrite0:
                    if (ramReady)
                        state <= sWrite1;
                sFlush1, sFill1, sWrite1:
                    if (ramReady)
                        state <= sRespond;
                sRespond:
                    if (respReady)
                        state <= sIdle;
                default:
                    state <= sIdle;
            endcase
        end
    end

    // request payload, snooped block and fill data share blockQ
    always_ff @(posedge CLK) begin
        if (acceptData) begin
            blockAddrQ <= granted.blockAddr;
            blockQ <= granted.block;
        end
        if (acceptInst)
            instAddrQ <= instReq[grant.core].addr;
        if (state == sSnoop && snoopDone && snoopResult.dirty)
            blockQ <= snoopResult.block;
        if ((state == sIFetch || state == sFill0 || state == sFill1) && ramReady)
            blockQ[wordIdx] <= ramLoad;
    end

    always_comb begin
        ramReqValid = 1'b0;
        ramReq.addr = {blockAddrQ, wordIdx, {ByteOffsetBits{1'b0}}};
        ramReq.write = 1'b0;
        ramReq.store = blockQ[wordIdx];
        unique case (state)
            sIFetch: begin
                ramReqValid = 1'b1;
                ramReq.addr = ramAddrT'(instAddrQ);
            end
            sFill0, sFill1:
                ramReqValid = 1'b1;
            sFlush0, sFlush1, sWrite0, sWrite1: begin
                ramReqValid = 1'b1;
                ramReq.write = 1'b1;
            end
            default: ;
        endcase
    end

    // snoop goes out in the accept cycle, the unit registers it
    assign snoopStart = acceptData && (granted.kind != writeBack);
    assign snoopTarget = ~grant.core;
    assign snoop = '{blockAddr: granted.blockAddr, invalidate: (granted.kind == busReadX)};

    always_comb begin
        for (int i = 0; i < NumCores; i++) begin
            dataReqReady[i] = acceptData && (grant.core == coreIdT'(i));
            instReqReady[i] = acceptInst && (grant.core == coreIdT'(i));
            dataResp[i].block = (kindQ == writeBack) ? '0 : blockQ;
            dataRespValid[i] = (state == sRespond) && isDataQ && (coreQ == coreIdT'(i));
            instResp[i].instr = blockQ[0];
            instRespValid[i] = (state == sRespond) && !isDataQ && (coreQ == coreIdT'(i));
        end
    end

    ramReqStable: assert property (
        @(posedge CLK) disable iff (!nRST)
        ramReqValid && !ramReady |=> ramReqValid && $stable(ramReq)
    );

    for (genvar i = 0; i < NumCores; i++) begin : gRespHold
        dataRespHeld: assert property (
            @(posedge CLK) disable iff (!nRST)
            dataRespValid[i] && !dataRespReady[i] |=> dataRespValid[i]
        );
        instRespHeld: assert property (
            @(posedge CLK) disable iff (!nRST)
            instRespValid[i] && !instRespReady[i] |=> instRespValid[i]
        );
    end

endmodule

`default_nettype wire

//--- snoopUnit.sv
`timescale 1ns/100ps
`default_nettype none

module snoopUnit (
    input  logic CLK,
    input  logic nRST,
    input  logic start,
    input  busTypesPkg::coreIdT target,
    input  busTypesPkg::snoopReqT snoop,
    output busTypesPkg::snoopReqT [busTypesPkg::NumCores-1:0] snoopReq,
    output logic [busTypesPkg::NumCores-1:0] snoopReqValid,
    input  logic [busTypesPkg::NumCores-1:0] snoopReqReady,
    input  busTypesPkg::snoopRespT [busTypesPkg::NumCores-1:0] snoopResp,
    input  logic [busTypesPkg::NumCores-1:0] snoopRespValid,
    output logic [busTypesPkg::NumCores-1:0] snoopRespReady,
    output logic done,
    output busTypesPkg::snoopRespT result
);
    import busTypesPkg::*;

    typedef enum logic [1:0] {
        sIdle,
        sRequest,
        sAwait
    } snoopStateT;

    snoopStateT state;
    coreIdT targetQ;
    logic doneQ;
    snoopReqT reqQ;
    snoopRespT resultQ;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= sIdle;
            targetQ <= '0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            unique case (state)
                sIdle:
                    if (start) begin
                        targetQ <= target;
                        state <= sRequest;
                    end
                sRequest:
                    if (snoopReqReady[targetQ])
                        state <= sAwait;
                sAwait:
                    if (snoopRespValid[targetQ]) begin
                        doneQ <= 1'b1;
                        state <= sIdle;
                    end
                default:
                    state <= sIdle;
            endcase
        end
    end

    // snoop payload and captured response
    always_ff @(posedge CLK) begin
        if (state == sIdle && start)
            reqQ <= snoop;
        if (state == sAwait && snoopRespValid[targetQ])
            resultQ <= snoopResp[targetQ];
    end

    // only the partner core sees the snoop
    always_comb begin
        for (int i = 0; i < NumCores; i++) begin
            snoopReq[i] = reqQ;
            snoopReqValid[i] = (state == sRequest) && (targetQ == coreIdT'(i));
            snoopRespReady[i] = (state == sAwait) && (targetQ == coreIdT'(i));
        end
    end

    assign done = doneQ;
    assign result = resultQ;

    // one snoop in flight, a new one starts only when the last is over
    singleSnoop: assert property (
        @(posedge CLK) disable iff (!nRST)
        start |-> state == sIdle
    );

endmodule

`default_nettype wire

//--- busArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module busArbiter (
    input  logic CLK,
    input  logic nRST,
    input  logic [busTypesPkg::NumCores-1:0] dataReqValid,
    input  logic [busTypesPkg::NumCores-1:0] instReqValid,
    input  logic idle,
    output busTypesPkg::grantT grant
);
    import busTypesPkg::*;

    grantT pick;
    grantT held;

    // data beats instructions, core 0 beats core 1
    always_comb begin
        pick = '0;
        for (int i = NumCores - 1; i >= 0; i--) begin
            if (instReqValid[i]) begin
                pick.isData = 1'b0;
                pick.core = coreIdT'(i);
                pick.valid = 1'b1;
            end
        end
        // data pass runs last so it overrides any instruction pick
        for (int i = NumCores - 1; i >= 0; i--) begin
            if (dataReqValid[i]) begin
                pick.isData = 1'b1;
                pick.core = coreIdT'(i);
                pick.valid = 1'b1;
            end
        end
    end

    // remember the winner for the rest of the transaction
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held <= '0;
        end else if (idle) begin
            held <= pick;
        end
    end

    assign grant = idle ? pick : held;

    // the sequencer only leaves idle on a valid grant, which then stays put
    grantHeld: assert property (
        @(posedge CLK) disable iff (!nRST)
        !idle |-> grant.valid && $stable(grant)
    );

endmodule

`default_nettype wire

//--- ramTypesPkg.sv
`default_nettype none

package ramTypesPkg;

    // byte-aligned word address, low two bits stay zero
    typedef logic [31:0] ramAddrT;

    // one word per access, write selects a store
    typedef struct packed {
        ramAddrT addr;
        logic write;
        busTypesPkg::wordT store;
    } ramReqT;

endpackage

`default_nettype wire

//--- busTypesPkg.sv
`default_nettype none

package busTypesPkg;

    // system geometry, fixed at two cores
    localparam int NumCores = 2;
    localparam int WordsPerBlock = 2;
    localparam int ByteOffsetBits = 2;
    localparam int WordIdxBits = $clog2(WordsPerBlock);
    localparam int BlockAddrBits = 32 - WordIdxBits - ByteOffsetBits;

    typedef logic [31:0] wordT;
    typedef logic [BlockAddrBits-1:0] blockAddrT;
    typedef logic [0:0] coreIdT;
    typedef wordT [WordsPerBlock-1:0] blockT;

    // data port request kinds
    typedef enum logic [1:0] {
        busRead,
        busReadX,
        writeBack
    } reqKindT;

    // block field carries store data for writeBack only
    typedef struct packed {
        reqKindT kind;
        blockAddrT blockAddr;
        blockT block;
    } dataReqT;

    typedef struct packed {
        blockT block;
    } dataRespT;

    typedef struct packed {
        wordT addr;
    } instReqT;

    typedef struct packed {
        wordT instr;
    } instRespT;

    typedef struct packed {
        blockAddrT blockAddr;
        logic invalidate;
    } snoopReqT;

    // block is meaningful only when dirty is set
    typedef struct packed {
        logic dirty;
        blockT block;
    } snoopRespT;

    typedef struct packed {
        logic isData;
        coreIdT core;
        logic valid;
    } grantT;

endpackage

`default_nettype wire
